// ==== files.f ====
+incdir+hw
hw/riscv_pkg.sv
hw/control_unit.sv
hw/imm_gen.sv
hw/reg_bank.sv
hw/id_stage.sv
hw/decode_top.sv
verification/decode_tb.sv

// ==== hw/control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
	input  riscv_pkg::rv_word_t instruction_i,
	output riscv_pkg::ctrl_t    ctrl_o
);

	riscv_pkg::rv_opcode_e opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;

	assign opcode = riscv_pkg::rv_opcode_e'(instruction_i[6:0]);
	assign funct3 = instruction_i[14:12];
	assign funct7 = instruction_i[31:25];

	// funct3 selects the arithmetic operation. alt picks SUB over ADD and SRA over SRL.
	function automatic riscv_pkg::rv_alu_op_e alu_from_funct3(
		input logic [2:0] f3,
		input logic       alt
	);
		riscv_pkg::rv_alu_op_e op;
		case (f3)
			3'b000: op = alt ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
			3'b001: op = riscv_pkg::ALU_SLL;
			3'b010: op = riscv_pkg::ALU_SLT;
			3'b011: op = riscv_pkg::ALU_SLTU;
			3'b100: op = riscv_pkg::ALU_XOR;
			3'b101: op = alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
			3'b110: op = riscv_pkg::ALU_OR;
			default: op = riscv_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	function automatic logic [2:0] load_code(input logic [2:0] f3);
		logic [2:0] code;
		case (f3)
			3'b000: code = 3'd1;
			3'b001: code = 3'd2;
			3'b010: code = 3'd3;
			3'b100: code = 3'd4;
			3'b101: code = 3'd5;
			default: code = 3'd0;
		endcase
		return code;
	endfunction

	function automatic logic [1:0] store_code(input logic [2:0] f3);
		logic [1:0] code;
		case (f3)
			3'b000: code = 2'd1;
			3'b001: code = 2'd2;
			3'b010: code = 2'd3;
			default: code = 2'd0;
		endcase
		return code;
	endfunction

	always_comb begin
		ctrl_o    = '0;
		ctrl_o.rd = instruction_i[11:7];
		case (opcode)
			riscv_pkg::OPC_OP: begin
				ctrl_o.alu_op   = alu_from_funct3(funct3, funct7[5]);
				ctrl_o.write_en = 1'b1;
				// the multiply/divide unit reuses funct3 through alu_op.
				ctrl_o.mdu_op   = (funct7 == 7'b0000001);
			end
			riscv_pkg::OPC_OP_IMM: begin
				// bit 30 is immediate data except for the shifts.
				ctrl_o.alu_op   = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
				ctrl_o.write_en = 1'b1;
				ctrl_o.imm_alu  = 1'b1;
			end
			riscv_pkg::OPC_LOAD: begin
				ctrl_o.alu_op    = riscv_pkg::ALU_ADD;
				ctrl_o.load_type = load_code(funct3);
				ctrl_o.write_en  = 1'b1;
				ctrl_o.imm_alu   = 1'b1;
			end
			riscv_pkg::OPC_STORE: begin
				ctrl_o.alu_op     = riscv_pkg::ALU_ADD;
				ctrl_o.store_type = store_code(funct3);
				ctrl_o.stype      = 1'b1;
				ctrl_o.imm_alu    = 1'b1;
			end
			riscv_pkg::OPC_BRANCH: begin
				if (!funct3[2]) begin
					ctrl_o.alu_op = riscv_pkg::ALU_SUB;
				end else if (funct3[1]) begin
					ctrl_o.alu_op = riscv_pkg::ALU_SLTU;
				end else begin
					ctrl_o.alu_op = riscv_pkg::ALU_SLT;
				end
				ctrl_o.branch_alu = 1'b1;
				// BEQ, BGE and BGEU are taken when the compare result is zero.
				ctrl_o.zeroflag   = funct3[2] ~^ funct3[0];
				ctrl_o.branch_pc  = 1'b1;
			end
			riscv_pkg::OPC_JAL: begin
				ctrl_o.alu_op    = riscv_pkg::ALU_ADD;
				ctrl_o.write_en  = 1'b1;
				ctrl_o.jtype     = 1'b1;
				ctrl_o.branch_pc = 1'b1;
			end
			riscv_pkg::OPC_JALR: begin
				ctrl_o.alu_op    = riscv_pkg::ALU_ADD;
				ctrl_o.write_en  = 1'b1;
				ctrl_o.jtype     = 1'b1;
				ctrl_o.imm_alu   = 1'b1;
				ctrl_o.branch_pc = 1'b1;
			end
			riscv_pkg::OPC_LUI: begin
				ctrl_o.alu_op   = riscv_pkg::ALU_PASS_B;
				ctrl_o.write_en = 1'b1;
				ctrl_o.utype    = 1'b1;
				ctrl_o.imm_alu  = 1'b1;
			end
			riscv_pkg::OPC_AUIPC: begin
				ctrl_o.alu_op    = riscv_pkg::ALU_ADD;
				ctrl_o.write_en  = 1'b1;
				ctrl_o.utype     = 1'b1;
				ctrl_o.imm_alu   = 1'b1;
				ctrl_o.auipc_alu = 1'b1;
			end
			default: begin
				// unknown opcodes travel on as a bubble.
				ctrl_o.write_en = 1'b0;
			end
		endcase
	end

endmodule

// ==== hw/decode_top.sv ====
`timescale 1ns/100ps

module decode_top (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  fetch_valid_i,
	input  riscv_pkg::fetch_pkt_t fetch_pkt_i,
	output logic                  fetch_credit_o,
	input  riscv_pkg::wb_pkt_t    wb_i,
	output logic                  op_valid_o,
	output riscv_pkg::op_pkt_t    op_o,
	input  logic                  ex_credit_i
);

	id_stage u_id (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.fetch_valid_i  (fetch_valid_i),
		.fetch_pkt_i    (fetch_pkt_i),
		.fetch_credit_o (fetch_credit_o),
		.wb_i           (wb_i),
		.op_valid_o     (op_valid_o),
		.op_o           (op_o),
		.ex_credit_i    (ex_credit_i)
	);

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module id_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  fetch_valid_i,
	input  riscv_pkg::fetch_pkt_t fetch_pkt_i,
	output logic                  fetch_credit_o,
	input  riscv_pkg::wb_pkt_t    wb_i,
	output logic                  op_valid_o,
	output riscv_pkg::op_pkt_t    op_o,
	input  logic                  ex_credit_i
);

	localparam int DEPTH  = `ID_IN_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int CNT_W  = $clog2(DEPTH + 1);
	localparam int CRED_W = $clog2(`ID_OUT_CREDITS + 1);

	riscv_pkg::fetch_pkt_t q_mem [DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      q_count;
	logic [CRED_W-1:0]     out_credits;
	logic                  pop;
	logic                  issued_q;
	riscv_pkg::fetch_pkt_t head;
	riscv_pkg::rv_word_t   rdata1;
	riscv_pkg::rv_word_t   rdata2;
	riscv_pkg::rv_word_t   imm;
	riscv_pkg::ctrl_t      dec_ctrl;
	riscv_pkg::ctrl_t      issue_ctrl;
	riscv_pkg::op_pkt_t    op_q;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head = q_mem[rd_ptr];
	assign pop  = (q_count != '0) && (out_credits != '0);

	reg_bank u_regs (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.raddr1_i (head.instruction[19:15]),
		.raddr2_i (head.instruction[24:20]),
		.wb_i     (wb_i),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	control_unit u_ctrl (
		.instruction_i (head.instruction),
		.ctrl_o        (dec_ctrl)
	);

	imm_gen u_imm (
		.instruction_i (head.instruction),
		.imm_o         (imm)
	);

	// a no-op entry leaves no architectural trace.
	always_comb begin
		issue_ctrl = dec_ctrl;
		if (head.no_op) begin
			issue_ctrl.write_en  = 1'b0;
			issue_ctrl.stype     = 1'b0;
			issue_ctrl.branch_pc = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid_i) begin
			q_mem[wr_ptr] <= fetch_pkt_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			q_count     <= '0;
			out_credits <= CRED_W'(`ID_OUT_CREDITS);
			issued_q    <= 1'b0;
		end else begin
			if (fetch_valid_i) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			q_count     <= q_count + CNT_W'(fetch_valid_i) - CNT_W'(pop);
			out_credits <= out_credits - CRED_W'(pop) + CRED_W'(ex_credit_i);
			issued_q    <= pop;
		end
	end

	// operands are sampled here, so a writeback on this edge is already forwarded.
	always_ff @(posedge clk) begin
		if (pop) begin
			op_q <= '{
				ctrl:     issue_ctrl,
				rdata1:   rdata1,
				rdata2:   rdata2,
				imm:      imm,
				pc_plus4: head.pc_plus4
			};
		end
	end

	// the freed queue slot goes back to fetch together with the issued packet.
	assign fetch_credit_o = issued_q;
	assign op_valid_o     = issued_q;
	assign op_o           = op_q;

	assert property (@(posedge clk) disable iff (!arst_n_i)
		fetch_valid_i |-> (q_count < CNT_W'(DEPTH)))
		else $error("id_stage: fetch pushed into a full input queue.");

	assert property (@(posedge clk) disable iff (!arst_n_i)
		out_credits <= CRED_W'(`ID_OUT_CREDITS))
		else $error("id_stage: execute credit count above its limit.");

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen (
	input  riscv_pkg::rv_word_t instruction_i,
	output riscv_pkg::rv_word_t imm_o
);

	riscv_pkg::rv_opcode_e opcode;
	logic                  sign;

	assign opcode = riscv_pkg::rv_opcode_e'(instruction_i[6:0]);
	assign sign   = instruction_i[31];

	always_comb begin
		case (opcode)
			riscv_pkg::OPC_OP_IMM,
			riscv_pkg::OPC_LOAD,
			riscv_pkg::OPC_JALR: begin
				imm_o = {{20{sign}}, instruction_i[31:20]};
			end
			riscv_pkg::OPC_STORE: begin
				imm_o = {{20{sign}}, instruction_i[31:25], instruction_i[11:7]};
			end
			riscv_pkg::OPC_BRANCH: begin
				imm_o = {{19{sign}}, sign, instruction_i[7], instruction_i[30:25],
					instruction_i[11:8], 1'b0};
			end
			riscv_pkg::OPC_LUI,
			riscv_pkg::OPC_AUIPC: begin
				imm_o = {instruction_i[31:12], 12'b0};
			end
			riscv_pkg::OPC_JAL: begin
				imm_o = {{11{sign}}, sign, instruction_i[19:12], instruction_i[20],
					instruction_i[30:21], 1'b0};
			end
			default: begin
				// register-register operations carry no immediate.
				imm_o = '0;
			end
		endcase
	end

endmodule

// ==== hw/reg_bank.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module reg_bank (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  riscv_pkg::rv_reg_addr_t raddr1_i,
	input  riscv_pkg::rv_reg_addr_t raddr2_i,
	input  riscv_pkg::wb_pkt_t      wb_i,
	output riscv_pkg::rv_word_t     rdata1_o,
	output riscv_pkg::rv_word_t     rdata2_o
);

	localparam int NUM_REGS = 1 << `RV_ADDR_WIDTH;

	// x0 is never written, so its entry keeps the value it was reset to.
	riscv_pkg::rv_word_t regs [NUM_REGS];
	logic                wr_hit;

	assign wr_hit = wb_i.wen && (wb_i.waddr != '0);

	function automatic riscv_pkg::rv_word_t read_port(input riscv_pkg::rv_reg_addr_t raddr);
		riscv_pkg::rv_word_t data;
		if (wr_hit && (wb_i.waddr == raddr)) begin
			// a write landing on the next edge is seen by the reader now.
			data = wb_i.wdata;
		end else begin
			data = regs[raddr];
		end
		return data;
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n_i)
		((raddr1_i != '0) || (rdata1_o == '0)) && ((raddr2_i != '0) || (rdata2_o == '0)))
		else $error("reg_bank: x0 read back nonzero.");

endmodule

// ==== hw/riscv_defs.svh ====
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// datapath widths of the integer core.
`define RV_WORD_WIDTH 32
`define RV_ADDR_WIDTH 5

// width of the ALU operation code carried to execute.
`define RV_ALU_OP_WIDTH 4

// the input queue holds one slot per fetch credit.
`define ID_IN_DEPTH 4

// number of packets the execute side can buffer.
`define ID_OUT_CREDITS 2

`endif

// ==== hw/riscv_pkg.sv ====
`include "riscv_defs.svh"

package riscv_pkg;

	typedef logic [`RV_WORD_WIDTH-1:0] rv_word_t;
	typedef logic [`RV_ADDR_WIDTH-1:0] rv_reg_addr_t;

	// major opcodes of RV32I, bits 6:0 of the instruction.
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111
	} rv_opcode_e;

	typedef enum logic [`RV_ALU_OP_WIDTH-1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} rv_alu_op_e;

	typedef struct packed {
		rv_word_t instruction;
		rv_word_t pc_plus4;
		logic     no_op;
	} fetch_pkt_t;

	typedef struct packed {
		rv_reg_addr_t waddr;
		rv_word_t     wdata;
		logic         wen;
	} wb_pkt_t;

	// load_type is 0 for none, then LB, LH, LW, LBU, LHU.
	// store_type is 0 for none, then SB, SH, SW.
	typedef struct packed {
		rv_alu_op_e   alu_op;
		logic [2:0]   load_type;
		logic [1:0]   store_type;
		logic         write_en;
		logic         stype;
		logic         utype;
		logic         jtype;
		logic         imm_alu;
		logic         auipc_alu;
		logic         branch_alu;
		logic         zeroflag;
		logic         branch_pc;
		logic         mdu_op;
		rv_reg_addr_t rd;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		rv_word_t rdata1;
		rv_word_t rdata2;
		rv_word_t imm;
		rv_word_t pc_plus4;
	} op_pkt_t;

endpackage

// ==== verification/decode_tb.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module decode_tb;

	localparam int NUM_VEC     = 14;
	localparam int IN_DEPTH    = `ID_IN_DEPTH;
	localparam int OUT_CREDITS = `ID_OUT_CREDITS;
	localparam int MAX_CYCLES  = 20 * NUM_VEC + 100;

	typedef struct packed {
		riscv_pkg::rv_word_t     instr;
		riscv_pkg::rv_word_t     pc4;
		logic                    no_op;
		logic                    wb_en;
		riscv_pkg::rv_reg_addr_t wb_addr;
		riscv_pkg::rv_word_t     wb_data;
		riscv_pkg::rv_alu_op_e   exp_alu;
		logic                    exp_we;
		logic                    exp_mdu;
		riscv_pkg::rv_reg_addr_t exp_rd;
		riscv_pkg::rv_word_t     exp_imm;
		logic [12:0]             exp_ctl;
	} vec_t;

	logic                  clk;
	logic                  arst_n_i;
	logic                  fetch_valid_i;
	riscv_pkg::fetch_pkt_t fetch_pkt_i;
	logic                  fetch_credit_o;
	riscv_pkg::wb_pkt_t    wb_i;
	logic                  op_valid_o;
	riscv_pkg::op_pkt_t    op_o;
	logic                  ex_credit_i;

	vec_t                tbl [NUM_VEC];
	riscv_pkg::rv_word_t ref_regs [32];
	riscv_pkg::op_pkt_t  rx_q [$];
	int                  rx_cyc [$];
	int                  cycles;
	int                  sent;
	int                  returned;
	int                  ex_held;
	logic                ex_hold;

	decode_top dut (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.fetch_valid_i  (fetch_valid_i),
		.fetch_pkt_i    (fetch_pkt_i),
		.fetch_credit_o (fetch_credit_o),
		.wb_i           (wb_i),
		.op_valid_o     (op_valid_o),
		.op_o           (op_o),
		.ex_credit_i    (ex_credit_i)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic load_table();
		// instruction, pc+4, no_op, writeback en/addr/data, then alu_op, write_en, mdu_op, rd, imm.
		// the last column is load_type, store_type, then stype down to branch_pc.
		tbl[0]  = '{32'h00500093, 32'h00001004, 1'b0, 1'b1, 5'd1, 32'h11111111,
			riscv_pkg::ALU_ADD, 1'b1, 1'b0, 5'd1, 32'h00000005, 13'b000_00_00010000};
		// x2 is written on the decode edge of this ADD.
		tbl[1]  = '{32'h002081B3, 32'h00001008, 1'b0, 1'b1, 5'd2, 32'h22222222,
			riscv_pkg::ALU_ADD, 1'b1, 1'b0, 5'd3, 32'h00000000, 13'b000_00_00000000};
		tbl[2]  = '{32'h40110233, 32'h0000100C, 1'b0, 1'b1, 5'd0, 32'hDEADBEEF,
			riscv_pkg::ALU_SUB, 1'b1, 1'b0, 5'd4, 32'h00000000, 13'b000_00_00000000};
		tbl[3]  = '{32'hFFC12283, 32'h00001010, 1'b0, 1'b1, 5'd5, 32'h55555555,
			riscv_pkg::ALU_ADD, 1'b1, 1'b0, 5'd5, 32'hFFFFFFFC, 13'b011_00_00010000};
		tbl[4]  = '{32'h0030A423, 32'h00001014, 1'b0, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_ADD, 1'b0, 1'b0, 5'd8, 32'h00000008, 13'b000_11_10010000};
		tbl[5]  = '{32'hFE208CE3, 32'h00001018, 1'b0, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_SUB, 1'b0, 1'b0, 5'd25, 32'hFFFFFFF8, 13'b000_00_00000111};
		tbl[6]  = '{32'h12345337, 32'h0000101C, 1'b0, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_PASS_B, 1'b1, 1'b0, 5'd6, 32'h12345000, 13'b000_00_01010000};
		tbl[7]  = '{32'h80000397, 32'h00001020, 1'b0, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_ADD, 1'b1, 1'b0, 5'd7, 32'h80000000, 13'b000_00_01011000};
		tbl[8]  = '{32'h801FF0EF, 32'h00001024, 1'b0, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_ADD, 1'b1, 1'b0, 5'd1, 32'hFFFFF800, 13'b000_00_00100001};
		tbl[9]  = '{32'h02308433, 32'h00001028, 1'b0, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_ADD, 1'b1, 1'b1, 5'd8, 32'h00000000, 13'b000_00_00000000};
		tbl[10] = '{32'h00128293, 32'h0000102C, 1'b1, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_ADD, 1'b0, 1'b0, 5'd5, 32'h00000001, 13'b000_00_00010000};
		// x5 must still hold its writeback value after the bubble.
		// the write to x0 lands while x0 is read and must not reach the reader.
		tbl[11] = '{32'h000284B3, 32'h00001030, 1'b0, 1'b1, 5'd0, 32'h0BADF00D,
			riscv_pkg::ALU_ADD, 1'b1, 1'b0, 5'd9, 32'h00000000, 13'b000_00_00000000};
		// bubbles of a store and a branch lose their side effects.
		tbl[12] = '{32'h0030A423, 32'h00001034, 1'b1, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_ADD, 1'b0, 1'b0, 5'd8, 32'h00000008, 13'b000_11_00010000};
		tbl[13] = '{32'hFE208CE3, 32'h00001038, 1'b1, 1'b0, 5'd0, 32'h00000000,
			riscv_pkg::ALU_SUB, 1'b0, 1'b0, 5'd25, 32'hFFFFFFF8, 13'b000_00_00000110};
	endtask

	function automatic riscv_pkg::rv_word_t expect_read(input riscv_pkg::rv_reg_addr_t addr);
		return (addr == '0) ? '0 : ref_regs[addr];
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] want);
		fail_run($sformatf("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, want));
	endtask

	task automatic check_packet(input riscv_pkg::op_pkt_t pkt, input vec_t v);
		riscv_pkg::rv_word_t exp1;
		riscv_pkg::rv_word_t exp2;
		logic [12:0]         got_ctl;
		exp1 = expect_read(v.instr[19:15]);
		exp2 = expect_read(v.instr[24:20]);
		got_ctl = {pkt.ctrl.load_type, pkt.ctrl.store_type, pkt.ctrl.stype, pkt.ctrl.utype,
			pkt.ctrl.jtype, pkt.ctrl.imm_alu, pkt.ctrl.auipc_alu, pkt.ctrl.branch_alu,
			pkt.ctrl.zeroflag, pkt.ctrl.branch_pc};
		assert (pkt.ctrl.alu_op == v.exp_alu)
			else report_mismatch("alu_op", 32'(pkt.ctrl.alu_op), 32'(v.exp_alu));
		assert (pkt.ctrl.write_en == v.exp_we)
			else report_mismatch("write_en", 32'(pkt.ctrl.write_en), 32'(v.exp_we));
		assert (pkt.ctrl.mdu_op == v.exp_mdu)
			else report_mismatch("mdu_op", 32'(pkt.ctrl.mdu_op), 32'(v.exp_mdu));
		assert (pkt.ctrl.rd == v.exp_rd)
			else report_mismatch("rd", 32'(pkt.ctrl.rd), 32'(v.exp_rd));
		assert (got_ctl == v.exp_ctl)
			else report_mismatch("control flags", 32'(got_ctl), 32'(v.exp_ctl));
		assert (pkt.imm == v.exp_imm) else report_mismatch("imm", pkt.imm, v.exp_imm);
		assert (pkt.rdata1 == exp1) else report_mismatch("rdata1", pkt.rdata1, exp1);
		assert (pkt.rdata2 == exp2) else report_mismatch("rdata2", pkt.rdata2, exp2);
		assert (pkt.pc_plus4 == v.pc4) else report_mismatch("pc_plus4", pkt.pc_plus4, v.pc4);
	endtask

	task automatic send_fetch(input riscv_pkg::rv_word_t instr, input riscv_pkg::rv_word_t pc4,
		input logic no_op, output int t_send);
		do @(posedge clk); while ((sent - returned) >= IN_DEPTH);
		@(negedge clk);
		fetch_valid_i = 1'b1;
		fetch_pkt_i   = '{instruction: instr, pc_plus4: pc4, no_op: no_op};
		sent++;
		@(posedge clk);
		t_send = cycles;
		@(negedge clk);
		fetch_valid_i = 1'b0;
	endtask

	task automatic apply_entry(input vec_t v);
		riscv_pkg::op_pkt_t pkt;
		int                 t_send;
		int                 t_arrive;
		// with an output credit in hand the decode edge follows acceptance directly.
		do @(posedge clk); while (ex_held >= OUT_CREDITS);
		send_fetch(v.instr, v.pc4, v.no_op, t_send);
		wb_i = '{waddr: v.wb_addr, wdata: v.wb_data, wen: v.wb_en};
		@(negedge clk);
		wb_i = '0;
		if (v.wb_en && (v.wb_addr != '0)) begin
			ref_regs[v.wb_addr] = v.wb_data;
		end
		do @(posedge clk); while (rx_q.size() == 0);
		pkt      = rx_q.pop_front();
		t_arrive = rx_cyc.pop_front();
		assert (t_arrive == t_send + 2)
			else report_mismatch("cycles from fetch to op_valid_o", 32'(t_arrive - t_send), 32'd2);
		check_packet(pkt, v);
	endtask

	// execute-side model and output monitor.
	initial begin
		void'($urandom(48));
		ex_credit_i = 1'b0;
		cycles      = 0;
		returned    = 0;
		ex_held     = 0;
		forever begin
			@(negedge clk);
			cycles++;
			assert (cycles <= MAX_CYCLES)
				else fail_run("Timeout: the DUT stopped issuing packets before the tests ended.");
			assert (fetch_credit_o == op_valid_o)
				else report_mismatch("fetch_credit_o", 32'(fetch_credit_o), 32'(op_valid_o));
			// the credit driven on the last falling edge was taken at the rising edge.
			if (ex_credit_i) begin
				ex_held--;
			end
			if (op_valid_o) begin
				ex_held++;
				rx_q.push_back(op_o);
				rx_cyc.push_back(cycles);
			end
			if (fetch_credit_o) begin
				returned++;
			end
			assert (ex_held <= OUT_CREDITS)
				else fail_run("The DUT issued more packets than the execute buffer holds.");
			ex_credit_i = !ex_hold && (ex_held > 0) && (($urandom() % 2) == 1);
		end
	end

	initial begin
		riscv_pkg::op_pkt_t pkt;
		int                 t_send;
		arst_n_i      = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_pkt_i   = '0;
		wb_i          = '0;
		ex_hold       = 1'b0;
		sent          = 0;
		for (int r = 0; r < 32; r++) begin
			ref_regs[r] = '0;
		end
		load_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		assert (!op_valid_o && !fetch_credit_o)
			else fail_run("op_valid_o or fetch_credit_o is high during reset.");
		arst_n_i = 1'b1;

		for (int i = 0; i < NUM_VEC; i++) begin
			apply_entry(tbl[i]);
		end

		// with no credits coming back only the first packets up to the buffer size leave.
		do @(posedge clk); while (ex_held != 0);
		ex_hold = 1'b1;
		for (int k = 0; k < IN_DEPTH; k++) begin
			send_fetch(32'h00000513 | ((k + 1) << 20), 32'h00002000 + 4 * k, 1'b0, t_send);
		end
		repeat (12) @(posedge clk);
		assert (rx_q.size() == OUT_CREDITS)
			else report_mismatch("packets issued under back-pressure", 32'(rx_q.size()),
				32'(OUT_CREDITS));
		assert (sent - returned == IN_DEPTH - OUT_CREDITS)
			else report_mismatch("fetch credits outstanding", 32'(sent - returned),
				32'(IN_DEPTH - OUT_CREDITS));
		ex_hold = 1'b0;
		do @(posedge clk); while (rx_q.size() < IN_DEPTH);
		for (int k = 0; k < IN_DEPTH; k++) begin
			pkt = rx_q.pop_front();
			assert (pkt.pc_plus4 == 32'h00002000 + 4 * k)
				else report_mismatch("pc_plus4 order", pkt.pc_plus4, 32'h00002000 + 4 * k);
			assert (pkt.imm == 32'(k + 1)) else report_mismatch("imm", pkt.imm, 32'(k + 1));
			assert (pkt.ctrl.rd == 5'd10) else report_mismatch("rd", 32'(pkt.ctrl.rd), 32'd10);
		end
		rx_cyc.delete();
		do @(posedge clk); while (returned != sent);

		$display("PASS: all tests");
		$finish;
	end

endmodule
